//--- core_mmu.f
+incdir+hw
hw/core/mmu/mmu_pkg.sv
hw/core/mmu/core_mmu_req_capture.sv
hw/core/mmu/core_mmu_pagewalk.sv
hw/core/mmu/core_mmu_arbiter.sv
hw/core/mmu/core_mmu.sv
tb/core_mmu_bus_model.sv
tb/core_mmu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the MMU testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing -Wno-fatal --top-module core_mmu_tb \
	-f core_mmu.f --Mdir obj_dir -o core_mmu_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
	cat "$build_log"
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/core_mmu_sim > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"

if grep -q "FAIL: see errors above" "$sim_log"; then
	echo "Simulation reported a failure"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi
if ! grep -q "PASS: all tests" "$sim_log"; then
	echo "Simulation ended without a result"
	exit 1
fi
exit 0

//--- tb/core_mmu_tb.sv
`timescale 1ns/1ps

module core_mmu_tb;

	import mmu_pkg::*;

	localparam int TIMEOUT = 200;

	typedef struct packed {
		logic [1:0]    port;    // 0 insn, 1 data, 2 both at once
		logic          enable;
		logic          user;
		logic          write;
		logic          ex_lock;
		word           vaddr;
		word           wdata;
		logic [3:0]    be;
		word           paddr;   // Expected physical byte address
		logic          fault;
		mmu_fault_type ftype;
		mmu_domain     domain;
		logic          page;
	} test_t;

	logic          clk = 1'b0;
	logic          rst_n, privileged, mmu_enable, bus_ready, bus_ex_fail;
	logic          insn_start, data_start, data_write, data_ex_lock, data_user;
	logic          bus_start, bus_write, bus_ex_lock, insn_ready, insn_fault;
	logic          data_ready, data_fault, data_ex_fail, fault_register, fault_page;
	logic [3:0]    data_data_be, bus_data_be;
	mmu_base       mmu_ttbr;
	word           mmu_dac, bus_data_rd, data_data_wr, bus_data_wr, insn_data_rd, data_data_rd;
	ptr            insn_addr, data_addr, bus_addr, fault_addr;
	mmu_fault_type fault_type;
	mmu_domain     fault_domain;

	test_t tests[$];
	string names[$];
	word   shadow[ptr];

	core_mmu core_mmu_inst (.*);
	core_mmu_bus_model bus_model (.*);

	always #2 clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "run aborted after a failed check");
	endtask

	task automatic check_word(string name, word exp, word act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_fault(string name, mmu_fault_type exp, mmu_fault_type act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_domain(string name, mmu_domain exp, mmu_domain act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_ptr(string name, ptr exp, ptr act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
			abort_run();
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Memory contents as the bus model defines them
	function automatic word expect_read(ptr a);
		return shadow.exists(a) ? shadow[a] : {a, 2'b00} ^ 32'h3c5a96e1;
	endfunction

	task automatic store(ptr a, word d, logic [3:0] be);
		word w;

		w = expect_read(a);
		for (int i = 0; i < 4; i++)
			if (be[i])
				w[8*i +: 8] = d[8*i +: 8];
		shadow[a] = w;
	endtask

	task automatic add(string name, int port, int en, int user, int wr, int ex, word va,
			word wd, int be, word pa, int flt, int ft, int dom, int pg);
		names.push_back(name);
		tests.push_back({2'(port), 1'(en), 1'(user), 1'(wr), 1'(ex), va, wd, 4'(be), pa,
			1'(flt), mmu_fault_type'(ft), mmu_domain'(dom), 1'(pg)});
	endtask

	task automatic check_data(string n, test_t t);
		ptr   pa;
		logic ex_exp;

		pa     = t.port == 2'd2 ? t.paddr[31:2] + 30'd1 : t.paddr[31:2];
		ex_exp = t.write && t.ex_lock && pa[0];
		check_flag({n, " data_fault"}, t.fault, data_fault);
		check_flag({n, " fault_register"}, t.fault, fault_register);
		if (t.fault) begin
			check_fault({n, " fault_type"}, t.ftype, fault_type);
			check_domain({n, " fault_domain"}, t.domain, fault_domain);
			check_flag({n, " fault_page"}, t.page, fault_page);
			check_ptr({n, " fault_addr"}, t.vaddr[31:2], fault_addr);
		end else begin
			check_flag({n, " data_ex_fail"}, ex_exp, data_ex_fail);
			if (!t.write)
				check_word({n, " data_data_rd"}, expect_read(pa), data_data_rd);
			else if (!ex_exp)
				store(pa, t.wdata, t.be);
		end
	endtask

	task automatic run_test(int i);
		test_t t;
		string n;
		logic  insn_done, data_done;
		int    cycles;

		t = tests[i];
		n = names[i];
		mmu_enable   = t.enable;
		data_user    = t.user;
		data_write   = t.write;
		data_ex_lock = t.ex_lock;
		data_data_wr = t.wdata;
		data_data_be = t.be;
		insn_addr    = t.vaddr[31:2];
		data_addr    = t.port == 2'd2 ? t.vaddr[31:2] + 30'd1 : t.vaddr[31:2];
		insn_start   = t.port != 2'd1;
		data_start   = t.port != 2'd0;
		@(negedge clk);
		insn_start = 1'b0;
		data_start = 1'b0;
		insn_done  = t.port == 2'd1;
		data_done  = t.port == 2'd0;
		cycles     = 0;
		while (!(insn_done && data_done)) begin
			if (cycles == TIMEOUT) begin
				$display("Test %s timed out waiting for the ready strobe", n);
				abort_run();
			end
			if (insn_ready && !insn_done) begin
				check_flag({n, " insn_fault"}, 1'b0, insn_fault);
				check_word({n, " insn_data_rd"}, expect_read(t.paddr[31:2]), insn_data_rd);
				insn_done = 1'b1;
			end
			if (data_ready && !data_done) begin
				check_data(n, t);
				data_done = 1'b1;
			end
			@(negedge clk);
			cycles++;
		end
	endtask

	initial begin
		rst_n        = 1'b0;
		privileged   = 1'b1;
		mmu_enable   = 1'b0;
		mmu_ttbr     = 18'h40;      // Tables at 0x0010_0000
		mmu_dac      = 32'h0000004d; // d0 client, d1 manager, d2 none, d3 client
		insn_addr    = '0;
		insn_start   = 1'b0;
		data_addr    = '0;
		data_start   = 1'b0;
		data_write   = 1'b0;
		data_data_wr = '0;
		data_data_be = '0;
		data_ex_lock = 1'b0;
		data_user    = 1'b0;

		// name, port, enable, user, write, excl, vaddr, wdata, be, paddr, fault, type, dom, page
		add("off_rd_insn", 0, 0, 0, 0, 0, 'h00001000, 0, 'hf, 'h00001000, 0, 0, 0, 0);
		add("off_wr_data", 1, 0, 0, 1, 0, 'h00002004, 'h11223344, 'hf, 'h00002004, 0, 0, 0, 0);
		add("off_rd_data", 1, 0, 0, 0, 0, 'h00002004, 0, 'hf, 'h00002004, 0, 0, 0, 0);
		add("off_rd_both", 2, 0, 0, 0, 0, 'h00003010, 0, 'hf, 'h00003010, 0, 0, 0, 0);
		add("sec_rd_insn", 0, 1, 0, 0, 0, 'h30000040, 0, 'hf, 'h00500040, 0, 0, 0, 0);
		add("sec_wr_data", 1, 1, 0, 1, 0, 'h30000108, 'hdeadbeef, 'h6, 'h00500108, 0, 0, 0, 0);
		add("sec_rd_back", 1, 1, 0, 0, 0, 'h30000108, 0, 'hf, 'h00500108, 0, 0, 0, 0);
		add("crs_rd_data", 1, 1, 0, 0, 0, 'h30105010, 0, 'hf, 'h00607010, 0, 0, 0, 0);
		add("crs_rd_insn", 0, 1, 0, 0, 0, 'h30105ffc, 0, 'hf, 'h00607ffc, 0, 0, 0, 0);
		add("flt_desc", 1, 1, 0, 0, 0, 'h30200020, 0, 'hf, 0, 1, 0, 0, 0);
		add("desc_after", 1, 1, 0, 0, 0, 'h30000200, 0, 'hf, 'h00500200, 0, 0, 0, 0);
		add("flt_domain", 1, 1, 0, 0, 0, 'h30300044, 0, 'hf, 0, 1, 1, 2, 0);
		add("dom_after", 1, 1, 0, 0, 0, 'h30105020, 0, 'hf, 'h00607020, 0, 0, 0, 0);
		add("flt_perm", 1, 1, 1, 1, 0, 'h30106008, 'hcafef00d, 'hf, 0, 1, 2, 3, 1);
		add("perm_user_rd", 1, 1, 1, 0, 0, 'h30106008, 0, 'hf, 'h00608008, 0, 0, 0, 0);
		add("mgr_wr_user", 1, 1, 1, 1, 0, 'h30400010, 'h0badf00d, 'h3, 'h00800010, 0, 0, 0, 0);
		add("mgr_rd_back", 1, 1, 0, 0, 0, 'h30400010, 0, 'hf, 'h00800010, 0, 0, 0, 0);
		add("both_sec", 2, 1, 0, 0, 0, 'h30000300, 0, 'hf, 'h00500300, 0, 0, 0, 0);
		add("both_coarse", 2, 1, 0, 0, 0, 'h30105040, 0, 'hf, 'h00607040, 0, 0, 0, 0);
		add("ex_wr_even", 1, 1, 0, 1, 1, 'h30000400, 'h12345678, 'hf, 'h00500400, 0, 0, 0, 0);
		add("ex_wr_odd", 1, 1, 0, 1, 1, 'h30000404, 'h87654321, 'hf, 'h00500404, 0, 0, 0, 0);
		add("ex_rd_even", 1, 1, 0, 0, 0, 'h30000400, 0, 'hf, 'h00500400, 0, 0, 0, 0);
		add("ex_rd_odd", 1, 1, 0, 0, 0, 'h30000404, 0, 'hf, 'h00500404, 0, 0, 0, 0);

		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_flag("reset insn_ready", 1'b0, insn_ready);
		check_flag("reset data_ready", 1'b0, data_ready);
		check_flag("reset insn_fault", 1'b0, insn_fault);
		check_flag("reset data_fault", 1'b0, data_fault);
		check_flag("reset bus_start", 1'b0, bus_start);
		check_flag("reset fault_page", 1'b0, fault_page);

		for (int i = 0; i < tests.size(); i++)
			run_test(i);

		$display("PASS: all tests");
		$finish;
	end

endmodule

//--- tb/core_mmu_bus_model.sv
`timescale 1ns/1ps

module core_mmu_bus_model
#(
	parameter mmu_pkg::mmu_base TTBR = 18'h40,
	parameter logic [31:0]      SEED = 32'h997c
)
(
	input  logic         clk,
	input  logic         rst_n,
	input  mmu_pkg::ptr  bus_addr,
	input  logic         bus_start,
	input  logic         bus_write,
	input  mmu_pkg::word bus_data_wr,
	input  logic [3:0]   bus_data_be,
	input  logic         bus_ex_lock,
	output logic         bus_ready,
	output logic         bus_ex_fail,
	output mmu_pkg::word bus_data_rd
);

	import mmu_pkg::*;

	localparam logic [21:0] L2_BASE = 22'h000800; // Coarse table at 0x0020_0000

	word          mem[ptr];
	mmu_bus_req_t held;
	logic [31:0]  lcg_state;
	int           delay;

	function automatic logic [31:0] lcg_next(logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Words never written read back a pattern of their own address
	function automatic word read_word(ptr a);
		return mem.exists(a) ? mem[a] : {a, 2'b00} ^ 32'h3c5a96e1;
	endfunction

	function automatic word merge(word old, word wr, logic [3:0] be);
		word w;

		w = old;
		for (int i = 0; i < 4; i++)
			if (be[i])
				w[8*i +: 8] = wr[8*i +: 8];
		return w;
	endfunction

	always @(negedge clk) begin
		if (!rst_n) begin
			mem[{TTBR, 12'h300}]  = 32'h00500c02; // Section to 0x005, AP 11, domain 0
			mem[{TTBR, 12'h301}]  = 32'h00200061; // Coarse table, domain 3
			mem[{TTBR, 12'h302}]  = 32'h00000000;
			mem[{TTBR, 12'h303}]  = 32'h00700c42; // Section in domain 2
			mem[{TTBR, 12'h304}]  = 32'h00800022; // AP 00 in manager domain 1
			mem[{L2_BASE, 8'h05}] = 32'h00607032; // Small page, AP 11
			mem[{L2_BASE, 8'h06}] = 32'h00608022; // Small page, AP 10
			bus_ready   <= 1'b0;
			bus_ex_fail <= 1'b0;
			bus_data_rd <= '0;
			delay       <= 0;
			lcg_state   <= SEED;
		end else begin
			bus_ready   <= 1'b0;
			bus_ex_fail <= 1'b0;
			if (bus_start) begin
				held      <= {bus_addr, bus_write, bus_data_wr, bus_data_be, bus_ex_lock};
				lcg_state <= lcg_next(lcg_state);
				delay     <= 1 + int'(lcg_state[29:28]); // Ready after 1 to 4 cycles
			end else if (delay == 1) begin
				delay       <= 0;
				bus_ready   <= 1'b1;
				bus_data_rd <= read_word(held.addr);
				if (held.write && held.ex_lock && held.addr[0])
					bus_ex_fail <= 1'b1; // The exclusive store is refused and memory is kept
				else if (held.write)
					mem[held.addr] = merge(read_word(held.addr), held.data_wr, held.data_be);
			end else if (delay > 1) begin
				delay <= delay - 1;
			end
		end
	end

endmodule

//--- hw/core/mmu/core_mmu.sv
`include "core/mmu/mmu_macros.svh"
`timescale 1ns/1ps

module core_mmu
(
	input  logic                   clk,
	                               rst_n,

	input  logic                   privileged,
	                               mmu_enable,
	input  mmu_pkg::mmu_base       mmu_ttbr,
	input  mmu_pkg::word           mmu_dac,

	input  logic                   bus_ready,
	                               bus_ex_fail,
	input  mmu_pkg::word           bus_data_rd,
	                               data_data_wr,
	input  mmu_pkg::ptr            insn_addr,
	                               data_addr,
	input  logic                   insn_start,
	                               data_start,
	                               data_write,
	                               data_ex_lock,
	                               data_user,
	input  logic [3:0]             data_data_be,

	output mmu_pkg::word           bus_data_wr,
	output logic [3:0]             bus_data_be,
	output mmu_pkg::ptr            bus_addr,
	output logic                   bus_start,
	                               bus_write,
	                               bus_ex_lock,
	                               insn_ready,
	                               insn_fault,
	                               data_ready,
	                               data_fault,
	                               data_ex_fail,
	output mmu_pkg::word           insn_data_rd,
	                               data_data_rd,

	output logic                   fault_register,
	                               fault_page,
	output mmu_pkg::ptr            fault_addr,
	output mmu_pkg::mmu_fault_type fault_type,
	output mmu_pkg::mmu_domain     fault_domain
);

	import mmu_pkg::*;

	mmu_req_t      req[`MMU_PORTS];
	mmu_bus_req_t  walk_bus_req[`MMU_PORTS];
	word           walk_data_rd[`MMU_PORTS], arb_data_rd[`MMU_PORTS];
	ptr            walk_fault_addr[`MMU_PORTS];
	mmu_fault_type walk_fault_type[`MMU_PORTS];
	mmu_domain     walk_fault_domain[`MMU_PORTS];

	logic [`MMU_PORTS-1:0] go, walk_ready, walk_fault, walk_ex_fail, walk_fault_page,
	                       walk_bus_start, arb_ready, arb_ex_fail;

	core_mmu_req_capture capture
	(
		.*
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// One walker per core port
	for (genvar p = 0; p < `MMU_PORTS; p++) begin : gen_walk
		core_mmu_pagewalk walk
		(
			.clk,
			.rst_n,
			.mmu_enable,
			.mmu_ttbr,
			.mmu_dac,
			.req(req[p]),
			.go(go[p]),
			.bus_ready(arb_ready[p]),
			.bus_ex_fail(arb_ex_fail[p]),
			.bus_data_rd(arb_data_rd[p]),
			.bus_start(walk_bus_start[p]),
			.bus_req(walk_bus_req[p]),
			.core_ready(walk_ready[p]),
			.core_fault(walk_fault[p]),
			.core_ex_fail(walk_ex_fail[p]),
			.core_data_rd(walk_data_rd[p]),
			.core_fault_addr(walk_fault_addr[p]),
			.core_fault_page(walk_fault_page[p]),
			.core_fault_type(walk_fault_type[p]),
			.core_fault_domain(walk_fault_domain[p])
		);
	end

	core_mmu_arbiter arbiter
	(
		.walk_start(walk_bus_start),
		.walk_req(walk_bus_req),
		.walk_ready(arb_ready),
		.walk_ex_fail(arb_ex_fail),
		.walk_data_rd(arb_data_rd),
		.*
	);

	assign insn_ready   = walk_ready[`MMU_PORT_INSN];
	assign insn_fault   = walk_fault[`MMU_PORT_INSN];
	assign insn_data_rd = walk_data_rd[`MMU_PORT_INSN];

	assign data_ready   = walk_ready[`MMU_PORT_DATA];
	assign data_fault   = walk_fault[`MMU_PORT_DATA];
	assign data_data_rd = walk_data_rd[`MMU_PORT_DATA];
	assign data_ex_fail = walk_ex_fail[`MMU_PORT_DATA];

	// Only data aborts reach the fault status registers
	assign fault_register = data_fault;
	assign fault_page     = walk_fault_page[`MMU_PORT_DATA];
	assign fault_addr     = walk_fault_addr[`MMU_PORT_DATA];
	assign fault_type     = walk_fault_type[`MMU_PORT_DATA];
	assign fault_domain   = walk_fault_domain[`MMU_PORT_DATA];

endmodule

//--- hw/core/mmu/core_mmu_arbiter.sv
`include "core/mmu/mmu_macros.svh"
`timescale 1ns/1ps

module core_mmu_arbiter
(
	input  logic                   clk,
	                               rst_n,

	input  logic [`MMU_PORTS-1:0]  walk_start,
	input  mmu_pkg::mmu_bus_req_t  walk_req[`MMU_PORTS],
	output logic [`MMU_PORTS-1:0]  walk_ready,
	                               walk_ex_fail,
	output mmu_pkg::word           walk_data_rd[`MMU_PORTS],

	input  logic                   bus_ready,
	                               bus_ex_fail,
	input  mmu_pkg::word           bus_data_rd,

	output mmu_pkg::ptr            bus_addr,
	output logic                   bus_start,
	                               bus_write,
	output mmu_pkg::word           bus_data_wr,
	output logic [3:0]             bus_data_be,
	output logic                   bus_ex_lock
);

	import mmu_pkg::*;

	localparam int GRANT_BITS = $clog2(`MMU_PORTS);

	logic [`MMU_PORTS-1:0] pending, waiting;
	logic [GRANT_BITS-1:0] grant;
	logic                  busy;

	assign waiting = pending | walk_start;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pending   <= '0;
			busy      <= 1'b0;
			grant     <= '0;
			bus_start <= 1'b0;
		end else begin
			bus_start <= 1'b0;
			pending   <= waiting;

			if (busy) begin
				if (bus_ready)
					busy <= 1'b0;
			end else if (waiting[`MMU_PORT_DATA]) begin
				grant                  <= GRANT_BITS'(`MMU_PORT_DATA); // Loads and stores win
				busy                   <= 1'b1;
				bus_start              <= 1'b1;
				pending[`MMU_PORT_DATA] <= 1'b0;
			end else if (waiting[`MMU_PORT_INSN]) begin
				grant                  <= GRANT_BITS'(`MMU_PORT_INSN);
				busy                   <= 1'b1;
				bus_start              <= 1'b1;
				pending[`MMU_PORT_INSN] <= 1'b0;
			end
		end
	end

	// Walkers hold their request until bus_ready, so it is read straight through
	assign bus_addr    = walk_req[grant].addr;
	assign bus_write   = walk_req[grant].write;
	assign bus_data_wr = walk_req[grant].data_wr;
	assign bus_data_be = walk_req[grant].data_be;
	assign bus_ex_lock = walk_req[grant].ex_lock;

	always_comb begin
		for (int p = 0; p < `MMU_PORTS; p++) begin
			walk_ready[p]   = busy && bus_ready && grant == GRANT_BITS'(p);
			walk_ex_fail[p] = bus_ex_fail && grant == GRANT_BITS'(p);
			walk_data_rd[p] = grant == GRANT_BITS'(p) ? bus_data_rd : '0;
		end
	end

endmodule

//--- hw/core/mmu/core_mmu_pagewalk.sv
`include "core/mmu/mmu_macros.svh"
`timescale 1ns/1ps

module core_mmu_pagewalk
(
	input  logic                   clk,
	                               rst_n,

	input  logic                   mmu_enable,
	input  mmu_pkg::mmu_base       mmu_ttbr,
	input  mmu_pkg::word           mmu_dac,

	input  mmu_pkg::mmu_req_t      req,
	input  logic                   go,

	input  logic                   bus_ready,
	                               bus_ex_fail,
	input  mmu_pkg::word           bus_data_rd,
	output logic                   bus_start,
	output mmu_pkg::mmu_bus_req_t  bus_req,

	output logic                   core_ready,
	                               core_fault,
	                               core_ex_fail,
	output mmu_pkg::word           core_data_rd,

	output mmu_pkg::ptr            core_fault_addr,
	output logic                   core_fault_page,
	output mmu_pkg::mmu_fault_type core_fault_type,
	output mmu_pkg::mmu_domain     core_fault_domain
);

	import mmu_pkg::*;

	mmu_walk_state state;
	mmu_domain     walk_domain, desc_domain;
	mmu_ap         desc_ap;
	mmu_fault_type desc_fault_type;
	ptr            desc_phys, l1_addr, l2_addr;
	logic [1:0]    dac_field;
	logic          walk_fault, xlat_fault, dom_fault, perm_fault, desc_fault, desc_coarse;

	function automatic mmu_bus_req_t table_read(ptr addr);
		mmu_bus_req_t r;

		r.addr    = addr;
		r.write   = 1'b0;
		r.data_wr = '0;
		r.data_be = 4'hf;
		r.ex_lock = 1'b0;
		return r;
	endfunction

	function automatic mmu_bus_req_t phys_access(ptr addr, mmu_req_t core_req);
		mmu_bus_req_t r;

		r.addr    = addr;
		r.write   = core_req.write;
		r.data_wr = core_req.data_wr;
		r.data_be = core_req.data_be;
		r.ex_lock = core_req.ex_lock;
		return r;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Descriptor decode and access checks on the word just read

	assign l1_addr = {mmu_ttbr, req.addr[29:18]};
	assign l2_addr = {bus_data_rd[31:10], req.addr[17:10]};
	assign desc_coarse = state == read_l1 && bus_data_rd[1:0] == `MMU_L1_COARSE;

	always_comb begin
		if (state == read_l2) begin
			desc_domain = walk_domain; // Coarse tables take the domain of their L1 entry
			desc_ap     = bus_data_rd[5:4];
			desc_phys   = {bus_data_rd[31:12], req.addr[9:0]};
			xlat_fault  = bus_data_rd[1:0] != `MMU_L2_SMALL;
		end else begin
			desc_domain = bus_data_rd[8:5];
			desc_ap     = bus_data_rd[11:10];
			desc_phys   = {bus_data_rd[31:20], req.addr[17:0]};
			xlat_fault  = bus_data_rd[1:0] != `MMU_L1_SECTION;
		end

		dac_field = mmu_dac[{desc_domain, 1'b0} +: 2];
		dom_fault = !dac_field[0]; // 00 and 10 both deny

		unique case (desc_ap)
			2'b00:   perm_fault = 1'b1;
			2'b01:   perm_fault = !req.privileged;
			2'b10:   perm_fault = !req.privileged && req.write;
			default: perm_fault = 1'b0;
		endcase

		if (dac_field[1])
			perm_fault = 1'b0; // Manager domains skip the AP check

		desc_fault = xlat_fault || dom_fault || perm_fault;

		if (xlat_fault)
			desc_fault_type = fault_translation;
		else if (dom_fault)
			desc_fault_type = fault_domain;
		else
			desc_fault_type = fault_permission;
	end

	assign core_ready = state == done;
	assign core_fault = core_ready && walk_fault;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Walk sequencing

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= idle;
			bus_start  <= 1'b0;
			walk_fault <= 1'b0;
		end else begin
			bus_start <= 1'b0;

			unique case (state)
				idle:
					if (go) begin
						walk_fault <= 1'b0;
						bus_start  <= 1'b1;
						state      <= mmu_enable ? read_l1 : access;
					end

				read_l1, read_l2:
					if (bus_ready) begin
						if (desc_coarse) begin
							bus_start <= 1'b1;
							state     <= read_l2;
						end else if (desc_fault) begin
							walk_fault <= 1'b1;
							state      <= done;
						end else begin
							bus_start <= 1'b1;
							state     <= access;
						end
					end

				access:
					if (bus_ready)
						state <= done;

				default:
					state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == idle && go)
			bus_req <= mmu_enable ? table_read(l1_addr) : phys_access(req.addr, req);

		if ((state == read_l1 || state == read_l2) && bus_ready) begin
			if (desc_coarse) begin
				bus_req     <= table_read(l2_addr);
				walk_domain <= desc_domain;
			end else begin
				bus_req <= phys_access(desc_phys, req);
			end
		end

		if (state == access && bus_ready) begin
			core_data_rd <= bus_data_rd;
			core_ex_fail <= bus_ex_fail;
		end
	end

	// Fault status stays until this walker faults again
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			core_fault_page <= 1'b0;
		end else if ((state == read_l1 || state == read_l2) && bus_ready
		             && !desc_coarse && desc_fault) begin
			core_fault_addr   <= req.addr;
			core_fault_page   <= state == read_l2;
			core_fault_type   <= desc_fault_type;
			core_fault_domain <= desc_domain;
		end
	end

endmodule

//--- hw/core/mmu/core_mmu_req_capture.sv
`include "core/mmu/mmu_macros.svh"
`timescale 1ns/1ps

module core_mmu_req_capture
(
	input  logic                   clk,
	                               rst_n,

	input  logic                   privileged,
	                               data_user,

	input  mmu_pkg::ptr            insn_addr,
	input  logic                   insn_start,

	input  mmu_pkg::ptr            data_addr,
	input  logic                   data_start,
	                               data_write,
	input  mmu_pkg::word           data_data_wr,
	input  logic [3:0]             data_data_be,
	input  logic                   data_ex_lock,

	output mmu_pkg::mmu_req_t      req[`MMU_PORTS],
	output logic [`MMU_PORTS-1:0]  go
);

	import mmu_pkg::*;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			go <= '0;
		end else begin
			go <= '0;
			go[`MMU_PORT_INSN] <= insn_start;
			go[`MMU_PORT_DATA] <= data_start;
		end
	end

	// Request slots hold their contents until the next start on that port
	always_ff @(posedge clk) begin
		if (insn_start) begin
			req[`MMU_PORT_INSN].addr       <= insn_addr;
			req[`MMU_PORT_INSN].write      <= 1'b0;
			req[`MMU_PORT_INSN].data_wr    <= '0;
			req[`MMU_PORT_INSN].data_be    <= 4'hf;  // Fetches always read the whole word
			req[`MMU_PORT_INSN].ex_lock    <= 1'b0;
			req[`MMU_PORT_INSN].privileged <= privileged;
		end

		if (data_start) begin
			req[`MMU_PORT_DATA].addr       <= data_addr;
			req[`MMU_PORT_DATA].write      <= data_write;
			req[`MMU_PORT_DATA].data_wr    <= data_data_wr;
			req[`MMU_PORT_DATA].data_be    <= data_data_be;
			req[`MMU_PORT_DATA].ex_lock    <= data_ex_lock;
			req[`MMU_PORT_DATA].privileged <= privileged && !data_user; // LDRT/STRT
		end
	end

endmodule

//--- hw/core/mmu/mmu_pkg.sv
package mmu_pkg;

	typedef logic [31:0] word;
	typedef logic [29:0] ptr;        // Byte address bits 31:2
	typedef logic [17:0] mmu_base;   // Table base, byte address bits 31:14
	typedef logic [3:0]  mmu_domain;
	typedef logic [1:0]  mmu_ap;

	typedef enum logic [1:0] {
		fault_translation,
		fault_domain,
		fault_permission
	} mmu_fault_type;

	typedef enum logic [2:0] {
		idle,
		read_l1,
		read_l2,
		access,
		done
	} mmu_walk_state;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// One captured core request
	typedef struct packed {
		ptr         addr;
		logic       write;
		word        data_wr;
		logic [3:0] data_be;
		logic       ex_lock;
		logic       privileged; // Effective privilege of this access
	} mmu_req_t;

	// One request on the external bus
	typedef struct packed {
		ptr         addr;
		logic       write;
		word        data_wr;
		logic [3:0] data_be;
		logic       ex_lock;
	} mmu_bus_req_t;

endpackage

//--- hw/core/mmu/mmu_macros.svh
`ifndef MMU_MACROS_SVH
`define MMU_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core-side ports served by the unit
`define MMU_PORTS      2
`define MMU_PORT_INSN  0
`define MMU_PORT_DATA  1

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Descriptor type codes in bits 1:0
`define MMU_L1_FAULT   2'b00
`define MMU_L1_COARSE  2'b01
`define MMU_L1_SECTION 2'b10

`define MMU_L2_SMALL   2'b10 // Large and tiny pages are not supported

`endif
